// File: Makefile
VERILATOR ?= verilator
TOP       ?= tinyCoreTb
RTL_TOP   ?= tinyCore
FILELIST  ?= tinyCore.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= all tests passed
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tinyCoreTb.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module tinyCoreTb;

    localparam int MAX_PAUSE = 16;  // Power of two, used as a mask

    logic clk = 1'b0;
    logic reset_n = 1'b0;
    logic halt = 1'b0;
    logic [`TC_WIDTH-1:0] iAddr, iData, dAddr, dIn, dOut;
    logic memWrite, strobe;

    logic [31:0] testData [0:127];
    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    int progLen, dataLen, storeCnt, pairBase;
    int storeIdx = 0;
    int errors = 0;
    integer seed = 50;

    tinyCore dut0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .halt     (halt),
        .iAddr    (iAddr),
        .iData    (iData),
        .dAddr    (dAddr),
        .dIn      (dIn),
        .dOut     (dOut),
        .memWrite (memWrite),
        .strobe   (strobe)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    assign iData = rom[iAddr[5:0]];  // Combinational ROM
    assign dIn   = ram[dAddr[5:0]];

    always @(posedge clk) begin
        if (strobe && memWrite) begin
            ram[dAddr[5:0]] <= dOut;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkIdle(input string when);
        check({when, " iAddr"}, `TC_RESET_VECTOR, iAddr);
        check({when, " strobe"}, 32'd0, 32'(strobe));
        check({when, " memWrite"}, 32'd0, 32'(memWrite));
    endtask

    task automatic loadTestData;
        $readmemh("dv/tinyCore_testdata.hex", testData);
        progLen  = testData[0];
        dataLen  = testData[1];
        storeCnt = testData[2];
        pairBase = 3 + progLen + dataLen;  // Expected (address, data) pairs
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
            ram[i] <= '0;
        end
        for (int i = 0; i < progLen; i++) begin
            rom[i] = testData[3 + i];
        end
        for (int i = 0; i < dataLen; i++) begin
            ram[i] <= testData[3 + progLen + i];
        end
    endtask

    task automatic finishRun;
        $display("Summary: %0d errors, %0d of %0d stores seen", errors, storeIdx, storeCnt);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // Store monitor, compares each store against the file in order
    always @(negedge clk) begin
        if (reset_n && strobe && memWrite) begin
            if (storeIdx < storeCnt) begin
                check($sformatf("store %0d address", storeIdx),
                      testData[pairBase + 2 * storeIdx], dAddr);
                check($sformatf("store %0d data", storeIdx),
                      testData[pairBase + 2 * storeIdx + 1], dOut);
            end else begin
                errors++;
                $display("Unexpected extra store of %h to address %h", dOut, dAddr);
            end
            storeIdx++;
        end
        if (halt && strobe) begin
            errors++;
            $display("Data strobe seen while halt was high at %0t", $time);
        end
    end

    // Random pause at the start of each new instruction address
    initial begin : haltDriver
        logic [31:0] lastAddr;
        int pause;
        lastAddr = ~`TC_RESET_VECTOR;
        @(posedge reset_n);
        forever begin
            @(negedge clk);
            if (iAddr !== lastAddr) begin
                lastAddr = iAddr;
                pause = $random(seed) & (MAX_PAUSE - 1);
                if (pause > 0) begin
                    @(posedge clk);
                    halt <= 1'b1;
                    repeat (pause) @(posedge clk);
                    halt <= 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        longint limitNs;
        @(posedge reset_n);
        limitNs = longint'(progLen) * (20 + MAX_PAUSE) * 40;
        #(limitNs);
        errors++;
        $display("Timeout: program did not reach its last instruction in %0d ns", limitNs);
        finishRun();
    end

    initial begin
        loadTestData();
        @(posedge clk);
        @(negedge clk);
        checkIdle("during reset");
        @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        checkIdle("after reset");
        wait (iAddr === progLen - 1);  // Last word spins on itself
        @(negedge clk);
        check("store count", storeCnt, storeIdx);
        finishRun();
    end

endmodule

// File: dv/tinyCore_testdata.hex
// Header: program length, data length, store count. Then program words,
// initial data memory words, and the expected store pairs (address data)
0000001A 00000004 00000012
C1000007 C2FFFFFD  // r1 = 7, r2 = -3
C3000020 E3000055  // r3 = 0x20, store immediate 0x55
23120000 23121001  // OR, AND
63122010 A3123005  // ADD, MUL
63125004 23126011  // SHL, LT
63127007 23128002  // EQ, GE
23129000 A312A0F0  // ANDN, XOR
2312B000 2312C000  // SUB, XNOR
A312D800 2312E100  // SHR, NE
A312F800 D4000002  // SAR, load r4 from data word 2
05412001 F5000030  // r5 = r4 + r1 + 1, store r5 at 0x30
0FF02001 E3000BAD  // PC-relative branch over the next store
E3000600 CF000019  // last store, then spin
11111111 22222222 12345678 44444444
00000020 00000055  00000020 FFFFFFFF  00000020 00000006  00000020 00000014
00000020 00000020  00000020 0000006D  00000020 00000011  00000020 FFFFFFFC
00000020 00000001  00000020 00000002  00000020 000000F4  00000020 0000000A
00000020 00000005  00000020 01FFFFED  00000020 000000FF  00000020 FFFFFFED
00000030 12345680  00000020 00000600

// File: rtl/aluPipe.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module aluPipe (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  tinyCorePkg::kind_e   kind,
    input  tinyCorePkg::opcode_e op,
    input  logic [`TC_WIDTH-1:0] valX,
    input  logic [`TC_WIDTH-1:0] valY,
    input  logic [`TC_WIDTH-1:0] imm,
    output logic                 done,
    output logic [`TC_WIDTH-1:0] result
);

    logic [`TC_WIDTH-1:0] opA, opB, opC;
    logic [`TC_WIDTH-1:0] aReg, bReg, cReg;
    logic [`TC_WIDTH-1:0] yReg, cDly, sumReg;
    tinyCorePkg::opcode_e opReg;
    logic [`TC_ALU_LATENCY-1:0] valid;

    always_comb begin
        unique case (kind)
            tinyCorePkg::XYI: {opA, opB, opC} = {valX, valY, imm};
            tinyCorePkg::XIY: {opA, opB, opC} = {valX, imm, valY};
            tinyCorePkg::IXY: {opA, opB, opC} = {imm, valX, valY};
            default:          {opA, opB, opC} = {{(2*`TC_WIDTH){1'b0}}, imm};
        endcase
    end

    always_ff @(posedge clk) begin
        aReg  <= opA;  // Stage 1
        bReg  <= opB;
        cReg  <= opC;
        opReg <= op;

        unique case (opReg)  // Stage 2
            tinyCorePkg::OP_OR:   yReg <= aReg | bReg;
            tinyCorePkg::OP_AND:  yReg <= aReg & bReg;
            tinyCorePkg::OP_ADD:  yReg <= aReg + bReg;
            tinyCorePkg::OP_MUL:  yReg <= aReg * bReg;
            tinyCorePkg::OP_RSVD: yReg <= '0;
            tinyCorePkg::OP_SHL:  yReg <= aReg << bReg;
            tinyCorePkg::OP_LT:   yReg <= {`TC_WIDTH{$signed(aReg) < $signed(bReg)}};
            tinyCorePkg::OP_EQ:   yReg <= {`TC_WIDTH{aReg == bReg}};
            tinyCorePkg::OP_GE:   yReg <= {`TC_WIDTH{$signed(aReg) >= $signed(bReg)}};
            tinyCorePkg::OP_ANDN: yReg <= aReg & ~bReg;
            tinyCorePkg::OP_XOR:  yReg <= aReg ^ bReg;
            tinyCorePkg::OP_SUB:  yReg <= aReg - bReg;
            tinyCorePkg::OP_XNOR: yReg <= aReg ~^ bReg;
            tinyCorePkg::OP_SHR:  yReg <= aReg >> bReg;
            tinyCorePkg::OP_NE:   yReg <= {`TC_WIDTH{aReg != bReg}};
            default:              yReg <= $signed(aReg) >>> bReg;  // SAR
        endcase
        cDly <= cReg;

        sumReg <= yReg + cDly;  // Stage 3
        result <= sumReg;       // Stage 4
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid <= '0;
        end else begin
            valid <= {valid[`TC_ALU_LATENCY-2:0], start};
        end
    end

    assign done = valid[`TC_ALU_LATENCY-1];

endmodule

// File: rtl/insnDecoder.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module insnDecoder (
    input  logic [`TC_WIDTH-1:0]  insn,
    output tinyCorePkg::decoded_t dec
);

    always_comb begin
        dec.kind     = tinyCorePkg::kind_e'(insn[31:30]);
        dec.storing  = insn[29];
        dec.derefRhs = insn[28];
        dec.idxZ     = insn[27:24];

        if (dec.kind == tinyCorePkg::IMM) begin
            // Wide immediate, no register operands
            dec.idxX = 4'd0;
            dec.idxY = 4'd0;
            dec.op   = tinyCorePkg::OP_OR;
            dec.imm  = {{(`TC_WIDTH-24){insn[23]}}, insn[23:0]};
        end else begin
            dec.idxX = insn[23:20];
            dec.idxY = insn[19:16];
            dec.op   = tinyCorePkg::opcode_e'(insn[15:12]);
            dec.imm  = {{(`TC_WIDTH-12){insn[11]}}, insn[11:0]};
        end

        dec.branching = (dec.idxZ == 4'd15) && !dec.storing;
        dec.loading   = dec.derefRhs && !dec.storing;
    end

endmodule

// File: rtl/memWaitTimer.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module memWaitTimer (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    output logic expired
);

    logic [3:0] count;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            count <= 4'(`TC_MEM_WAIT - 1);  // Start cycle counts as the first
        end else if (count != '0) begin
            count <= count - 4'd1;
        end
    end

    assign expired = (count == '0);

endmodule

// File: rtl/phaseSequencer.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module phaseSequencer (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  halt,
    input  logic                  aluDone,
    input  logic                  waitExpired,
    input  tinyCorePkg::decoded_t dec,
    input  logic [`TC_WIDTH-1:0]  aluResult,
    input  logic [`TC_WIDTH-1:0]  dIn,
    input  logic [`TC_WIDTH-1:0]  iData,
    output logic                  aluStart,
    output logic                  waitStart,
    output logic                  strobe,
    output logic                  regWrite,
    output logic [`TC_WIDTH-1:0]  insn,
    output logic [`TC_WIDTH-1:0]  iAddr,
    output logic [`TC_WIDTH-1:0]  nextPc,
    output logic [`TC_WIDTH-1:0]  rhs,
    output logic [`TC_WIDTH-1:0]  writeBack
);

    tinyCorePkg::phase_e phase;
    logic [`TC_WIDTH-1:0] memData;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase <= tinyCorePkg::NEXTADDR;
            iAddr <= `TC_RESET_VECTOR;
            insn  <= '0;  // Decodes as a plain register op, never a store
        end else begin
            unique case (phase)
                tinyCorePkg::EXEC: begin
                    if (!halt) phase <= tinyCorePkg::ALUWAIT;
                end
                tinyCorePkg::ALUWAIT: begin
                    if (aluDone) begin
                        rhs   <= aluResult;
                        phase <= tinyCorePkg::MEMWAIT;
                    end
                end
                tinyCorePkg::MEMWAIT: begin
                    if (waitExpired) phase <= tinyCorePkg::MEMLATCH;
                end
                tinyCorePkg::MEMLATCH: begin
                    memData <= dIn;
                    phase   <= tinyCorePkg::WRITEBACK;
                end
                tinyCorePkg::WRITEBACK: begin
                    iAddr <= dec.branching ? writeBack : nextPc;
                    phase <= tinyCorePkg::NEXTADDR;
                end
                tinyCorePkg::NEXTADDR: begin
                    nextPc <= iAddr + `TC_WIDTH'(1);
                    phase  <= tinyCorePkg::FETCH;
                end
                default: begin  // FETCH
                    insn  <= iData;
                    phase <= tinyCorePkg::EXEC;
                end
            endcase
        end
    end

    assign aluStart  = (phase == tinyCorePkg::EXEC) && !halt;
    assign waitStart = (phase == tinyCorePkg::ALUWAIT) && aluDone;
    assign strobe    = (phase == tinyCorePkg::MEMLATCH) && (dec.loading || dec.storing);
    assign regWrite  = (phase == tinyCorePkg::WRITEBACK) && !dec.storing;
    assign writeBack = dec.derefRhs ? memData : rhs;

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module regFile (
    input  logic                 clk,
    input  logic                 writeEn,
    input  logic [3:0]           idxZ,
    input  logic [3:0]           idxX,
    input  logic [3:0]           idxY,
    input  logic [`TC_WIDTH-1:0] writeData,
    input  logic [`TC_WIDTH-1:0] nextPc,
    output logic [`TC_WIDTH-1:0] valZ,
    output logic [`TC_WIDTH-1:0] valX,
    output logic [`TC_WIDTH-1:0] valY
);

    logic [`TC_WIDTH-1:0] regs [0:14];

    function automatic logic [`TC_WIDTH-1:0] readReg(input logic [3:0] idx);
        if (idx == 4'd0) return '0;
        if (idx == 4'd15) return nextPc;  // PC alias
        return regs[idx];
    endfunction

    assign valZ = readReg(idxZ);
    assign valX = readReg(idxX);
    assign valY = readReg(idxY);

    always_ff @(posedge clk) begin
        if (writeEn && idxZ != 4'd0 && idxZ != 4'd15) begin
            regs[idxZ] <= writeData;
        end
    end

endmodule

// File: rtl/tinyCore.sv
`timescale 1ns/1ps
`include "tinyCoreParams.svh"

module tinyCore (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 halt,
    output logic [`TC_WIDTH-1:0] iAddr,
    input  logic [`TC_WIDTH-1:0] iData,
    output logic [`TC_WIDTH-1:0] dAddr,
    input  logic [`TC_WIDTH-1:0] dIn,
    output logic [`TC_WIDTH-1:0] dOut,
    output logic                 memWrite,
    output logic                 strobe
);

    tinyCorePkg::decoded_t dec;

    logic [`TC_WIDTH-1:0] insn, nextPc, rhs, writeBack;
    logic [`TC_WIDTH-1:0] valZ, valX, valY, aluResult;
    logic aluStart, aluDone, waitStart, waitExpired, regWrite;

    insnDecoder decoder0 (
        .insn (insn),
        .dec  (dec)
    );

    regFile regs0 (
        .clk       (clk),
        .writeEn   (regWrite),
        .idxZ      (dec.idxZ),
        .idxX      (dec.idxX),
        .idxY      (dec.idxY),
        .writeData (writeBack),
        .nextPc    (nextPc),
        .valZ      (valZ),
        .valX      (valX),
        .valY      (valY)
    );

    aluPipe alu0 (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (aluStart),
        .kind    (dec.kind),
        .op      (dec.op),
        .valX    (valX),
        .valY    (valY),
        .imm     (dec.imm),
        .done    (aluDone),
        .result  (aluResult)
    );

    memWaitTimer timer0 (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (waitStart),
        .expired (waitExpired)
    );

    phaseSequencer seq0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .halt        (halt),
        .aluDone     (aluDone),
        .waitExpired (waitExpired),
        .dec         (dec),
        .aluResult   (aluResult),
        .dIn         (dIn),
        .iData       (iData),
        .aluStart    (aluStart),
        .waitStart   (waitStart),
        .strobe      (strobe),
        .regWrite    (regWrite),
        .insn        (insn),
        .iAddr       (iAddr),
        .nextPc      (nextPc),
        .rhs         (rhs),
        .writeBack   (writeBack)
    );

    // With derefRhs the ALU result is the address, otherwise Z is
    assign dAddr    = dec.derefRhs ? rhs : valZ;
    assign dOut     = dec.derefRhs ? valZ : rhs;
    assign memWrite = dec.storing;

endmodule

// File: rtl/tinyCoreParams.svh
`ifndef TINY_CORE_PARAMS_SVH
`define TINY_CORE_PARAMS_SVH

// Data and address width
`define TC_WIDTH 32

// First instruction address after reset
`define TC_RESET_VECTOR 32'h0000_0000

// Fixed by the four ALU stages
`define TC_ALU_LATENCY 4

// Legal range 1 to 15
`define TC_MEM_WAIT 1

`endif

// File: rtl/tinyCorePkg.sv
`include "tinyCoreParams.svh"

package tinyCorePkg;

    typedef enum logic [2:0] {
        EXEC, ALUWAIT, MEMWAIT, MEMLATCH, WRITEBACK, NEXTADDR, FETCH
    } phase_e;

    typedef enum logic [3:0] {
        OP_OR,   OP_AND,  OP_ADD, OP_MUL,
        OP_RSVD, OP_SHL,  OP_LT,  OP_EQ,
        OP_GE,   OP_ANDN, OP_XOR, OP_SUB,
        OP_XNOR, OP_SHR,  OP_NE,  OP_SAR
    } opcode_e;

    typedef enum logic [1:0] {
        XYI, XIY, IXY, IMM
    } kind_e;

    typedef struct packed {
        kind_e                kind;
        logic                 storing;
        logic                 derefRhs;
        opcode_e              op;
        logic [3:0]           idxZ;
        logic [3:0]           idxX;
        logic [3:0]           idxY;
        logic [`TC_WIDTH-1:0] imm;       // Already sign-extended
        logic                 branching; // Z is the program counter
        logic                 loading;
    } decoded_t;

endpackage

// File: tinyCore.f
+incdir+rtl
rtl/tinyCorePkg.sv
rtl/regFile.sv
rtl/insnDecoder.sv
rtl/aluPipe.sv
rtl/memWaitTimer.sv
rtl/phaseSequencer.sv
rtl/tinyCore.sv
dv/tinyCoreTb.sv
